//--- source/dma_pkg.sv
/* Shared widths, burst limits and response codes of the DMA write path,
   plus the transfer mode, burst type and write FSM state enums */

package dma_pkg;

   // ************************************************************************
   // Widths
   // ************************************************************************

   localparam int data_w      = 64;
   localparam int addr_w      = 32;
   localparam int length_w    = 8;
   localparam int burst_len_w = 4;
   localparam int perf_cntr_w = 16;

   // Descriptor word is {dest_addr, length, mode}
   localparam int desc_w = addr_w + length_w + 2;

   // ************************************************************************
   // Burst limits
   // ************************************************************************

   localparam int max_burst_beats = 2 ** burst_len_w;
   localparam int beat_bytes      = data_w / 8;

   // Address step from one burst to the next
   localparam logic [addr_w-1:0] burst_bytes = addr_w'(max_burst_beats * beat_bytes);

   // ************************************************************************
   // Encodings
   // ************************************************************************

   typedef enum logic [1:0] {
      stand_by    = 2'd0,
      host_to_ddr = 2'd1,
      ddr_to_host = 2'd2,
      ddr_to_ddr  = 2'd3
   } t_dma_mode;

   typedef enum logic [1:0] {
      burst_fixed = 2'd0,
      burst_incr  = 2'd1,
      burst_wrap  = 2'd2
   } t_burst;

   typedef enum logic [1:0] {
      okay   = 2'd0,
      exokay = 2'd1,
      slverr = 2'd2,
      decerr = 2'd3
   } t_resp;

   // One-hot, one bit per state
   typedef enum logic [5:0] {
      idle            = 6'b000001,
      addr_setup      = 6'b000010,
      fifo_empty      = 6'b000100,
      rd_fifo_wr_dest = 6'b001000,
      wait_for_wr_rsp = 6'b010000,
      error           = 6'b100000
   } t_wr_state;

endpackage

//--- source/dma_sync_fifo.sv
/* Synchronous first-word-fall-through queue with configurable width and depth */

`timescale 1ns/1ps

module dma_sync_fifo #(
   parameter int width = 64,
   parameter int depth = 32
) (
   input  logic             clk,
   input  logic             reset_n,
   input  logic             push,
   input  logic             pop,
   input  logic [width-1:0] push_data,
   output logic [width-1:0] pop_data,
   output logic             full,
   output logic             not_empty
);

   // Depth must be a power of two so the pointers wrap on their own
   logic [width-1:0]         mem [depth];
   logic [$clog2(depth)-1:0] wr_ptr;
   logic [$clog2(depth)-1:0] rd_ptr;
   logic [$clog2(depth):0]   count;

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         unique case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Head word shows as soon as it is stored
   assign pop_data  = mem[rd_ptr];
   assign not_empty = |count;
   // MSB of the count is only set when every slot holds a word
   assign full      = count[$clog2(depth)];

endmodule

//--- source/write_dest_fsm.sv
/* Write-destination FSM: splits a descriptor into bursts, streams beats
   from the data queue and waits for each write response */

`timescale 1ns/1ps

module write_dest_fsm (
   input  logic                         clk,
   input  logic                         reset_n,
   // Descriptor queue
   input  logic                         desc_not_empty,
   input  logic [dma_pkg::desc_w-1:0]   desc_data,
   output logic                         desc_pop,
   // Data queue
   input  logic                         data_not_empty,
   input  logic [dma_pkg::data_w-1:0]   data_rd,
   output logic                         data_pop,
   // Write bus
   output logic                         awvalid,
   output logic [dma_pkg::addr_w-1:0]   awaddr,
   output logic [dma_pkg::burst_len_w-1:0] awlen,
   output dma_pkg::t_burst              awburst,
   input  logic                         awready,
   output logic                         wvalid,
   output logic [dma_pkg::data_w-1:0]   wdata,
   output logic                         wlast,
   input  logic                         wready,
   input  logic                         bvalid,
   input  dma_pkg::t_resp               bresp,
   // Host control
   input  logic                         dispatcher_en,
   input  logic                         reset_dispatcher,
   // Status
   output logic                         wr_fsm_done,
   output dma_pkg::t_wr_state           wr_state,
   output logic                         start,
   output logic                         beat,
   output logic                         active,
   output logic                         rsp_err,
   output logic                         in_error
);

   function automatic dma_pkg::t_burst mode_to_burst(input dma_pkg::t_dma_mode mode);
      unique case (mode)
         dma_pkg::host_to_ddr: return dma_pkg::burst_incr;
         dma_pkg::ddr_to_host: return dma_pkg::burst_wrap;
         dma_pkg::ddr_to_ddr:  return dma_pkg::burst_incr;
         default:              return dma_pkg::burst_fixed;
      endcase
   endfunction

   dma_pkg::t_wr_state state;
   dma_pkg::t_wr_state next_state;

   logic [dma_pkg::addr_w-1:0]              desc_addr;
   logic [dma_pkg::length_w-1:0]            desc_len;
   logic [dma_pkg::length_w-1:0]            desc_len_m1;
   dma_pkg::t_dma_mode                      desc_mode;
   logic [dma_pkg::length_w-dma_pkg::burst_len_w:0] num_bursts;
   logic [dma_pkg::length_w-dma_pkg::burst_len_w:0] wlast_cnt;
   logic [dma_pkg::burst_len_w-1:0]         beat_cnt;
   logic [dma_pkg::burst_len_w-1:0]         last_len;
   logic                                    w_beat;
   logic                                    last_beat;
   logic                                    rsp_good;
   logic                                    more_bursts;

   // Descriptor word is {dest_addr, length, mode}
   assign desc_addr   = desc_data[dma_pkg::desc_w-1 -: dma_pkg::addr_w];
   assign desc_len    = desc_data[2 +: dma_pkg::length_w];
   assign desc_mode   = dma_pkg::t_dma_mode'(desc_data[1:0]);
   assign desc_len_m1 = desc_len - 1'b1;

   assign w_beat      = wvalid & wready;
   assign last_beat   = w_beat & wlast;
   assign rsp_good    = (state == dma_pkg::wait_for_wr_rsp) & bvalid &
                        ((bresp == dma_pkg::okay) | (bresp == dma_pkg::exokay));
   assign more_bursts = wlast_cnt < num_bursts;

   // ************************************************************************
   // State transitions
   // ************************************************************************

   always_comb begin
      next_state = state;
      unique case (state)
         dma_pkg::idle:
            if (dispatcher_en && desc_not_empty) next_state = dma_pkg::addr_setup;
         dma_pkg::addr_setup:
            if (awready) next_state = dma_pkg::rd_fifo_wr_dest;
         dma_pkg::fifo_empty:
            if (data_not_empty) next_state = dma_pkg::rd_fifo_wr_dest;
         dma_pkg::rd_fifo_wr_dest: begin
            if (last_beat) next_state = dma_pkg::wait_for_wr_rsp;
            else if (!data_not_empty) next_state = dma_pkg::fifo_empty;
         end
         dma_pkg::wait_for_wr_rsp: begin
            if (rsp_good) next_state = more_bursts ? dma_pkg::addr_setup : dma_pkg::idle;
            else if (rsp_err) next_state = dma_pkg::error;
         end
         dma_pkg::error:
            if (reset_dispatcher) next_state = dma_pkg::idle;
         default:
            next_state = dma_pkg::idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state      <= dma_pkg::idle;
         num_bursts <= '0;
         wlast_cnt  <= '0;
         beat_cnt   <= '0;
      end else begin
         state <= next_state;
         // Burst count is the length over 16, rounded up
         if (start) begin
            num_bursts <= {1'b0, desc_len_m1[dma_pkg::length_w-1:dma_pkg::burst_len_w]} + 1'b1;
            wlast_cnt  <= '0;
         end else if (last_beat) begin
            wlast_cnt <= wlast_cnt + 1'b1;
         end
         // Counts down to zero on the final beat of the burst
         if (awvalid && awready) begin
            beat_cnt <= awlen;
         end else if (w_beat) begin
            beat_cnt <= beat_cnt - 1'b1;
         end
      end
   end

   // ************************************************************************
   // Address channel
   // ************************************************************************

   always_ff @(posedge clk) begin
      if (start) begin
         awaddr   <= desc_addr;
         awburst  <= mode_to_burst(desc_mode);
         last_len <= desc_len_m1[dma_pkg::burst_len_w-1:0];
         if (desc_len_m1[dma_pkg::length_w-1:dma_pkg::burst_len_w] != '0) begin
            awlen <= '1;
         end else begin
            awlen <= desc_len_m1[dma_pkg::burst_len_w-1:0];
         end
      end else if (rsp_good && more_bursts) begin
         awaddr <= awaddr + dma_pkg::burst_bytes;
         // The final burst carries whatever is left of the length
         awlen  <= (wlast_cnt == num_bursts - 1'b1) ? last_len : '1;
      end
   end

   assign awvalid = (state == dma_pkg::addr_setup);

   // ************************************************************************
   // Data channel and status
   // ************************************************************************

   assign wvalid   = (state == dma_pkg::rd_fifo_wr_dest) & data_not_empty;
   assign wdata    = data_rd;
   assign wlast    = wvalid & (beat_cnt == '0);
   assign data_pop = w_beat;

   assign desc_pop    = (state == dma_pkg::idle) & dispatcher_en & desc_not_empty;
   assign start       = desc_pop;
   assign beat        = w_beat;
   assign active      = (state == dma_pkg::addr_setup) | (state == dma_pkg::fifo_empty) |
                        (state == dma_pkg::rd_fifo_wr_dest) |
                        (state == dma_pkg::wait_for_wr_rsp);
   assign rsp_err     = (state == dma_pkg::wait_for_wr_rsp) & bvalid &
                        ((bresp == dma_pkg::slverr) | (bresp == dma_pkg::decerr));
   assign in_error    = (state == dma_pkg::error);
   assign wr_fsm_done = rsp_good & ~more_bursts;
   assign wr_state    = state;

endmodule

//--- source/dma_wr_status.sv
/* Busy and error flags plus the clock and beat counters of the write stage */

`timescale 1ns/1ps

module dma_wr_status (
   input  logic                            clk,
   input  logic                            reset_n,
   input  logic                            start,
   input  logic                            beat,
   input  logic                            active,
   input  logic                            rsp_err,
   input  logic                            in_error,
   output logic                            busy,
   output logic                            stopped_on_error,
   output logic                            wr_rsp_err,
   output logic [dma_pkg::perf_cntr_w-1:0] wr_clk_cnt,
   output logic [dma_pkg::perf_cntr_w-1:0] wr_valid_cnt
);

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         busy             <= 1'b0;
         stopped_on_error <= 1'b0;
         wr_rsp_err       <= 1'b0;
      end else begin
         // Stays up through a stop on error until the dispatcher is reset
         busy             <= start | active | in_error;
         stopped_on_error <= in_error;
         if (start) begin
            wr_rsp_err <= 1'b0;
         end else if (rsp_err) begin
            wr_rsp_err <= 1'b1;
         end
      end
   end

   // ************************************************************************
   // Performance counters, cleared at each new descriptor
   // ************************************************************************

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         wr_clk_cnt   <= '0;
         wr_valid_cnt <= '0;
      end else if (start) begin
         wr_clk_cnt   <= '0;
         wr_valid_cnt <= '0;
      end else begin
         if (active) begin
            wr_clk_cnt <= wr_clk_cnt + 1'b1;
         end
         if (beat) begin
            wr_valid_cnt <= wr_valid_cnt + 1'b1;
         end
      end
   end

endmodule

//--- source/dma_write_top.sv
/* Write half of the DMA engine: descriptor and data queues, the
   write-destination FSM and its status block */

`timescale 1ns/1ps

module dma_write_top (
   input  logic                            clk,
   input  logic                            reset_n,
   // Host side
   input  logic                            desc_push,
   input  logic [dma_pkg::addr_w-1:0]      desc_dest_addr,
   input  logic [dma_pkg::length_w-1:0]    desc_length,
   input  dma_pkg::t_dma_mode              desc_mode,
   output logic                            desc_full,
   input  logic                            data_push,
   input  logic [dma_pkg::data_w-1:0]      data_in,
   output logic                            data_full,
   // Write bus
   output logic                            awvalid,
   output logic [dma_pkg::addr_w-1:0]      awaddr,
   output logic [dma_pkg::burst_len_w-1:0] awlen,
   output dma_pkg::t_burst                 awburst,
   input  logic                            awready,
   output logic                            wvalid,
   output logic [dma_pkg::data_w-1:0]      wdata,
   output logic                            wlast,
   input  logic                            wready,
   input  logic                            bvalid,
   input  dma_pkg::t_resp                  bresp,
   // Control and status
   input  logic                            dispatcher_en,
   input  logic                            reset_dispatcher,
   output logic                            wr_fsm_done,
   output dma_pkg::t_wr_state              wr_state,
   output logic                            busy,
   output logic                            stopped_on_error,
   output logic                            wr_rsp_err,
   output logic [dma_pkg::perf_cntr_w-1:0] wr_clk_cnt,
   output logic [dma_pkg::perf_cntr_w-1:0] wr_valid_cnt
);

   logic [dma_pkg::desc_w-1:0] desc_word;
   logic [dma_pkg::desc_w-1:0] desc_head;
   logic                       desc_not_empty;
   logic                       desc_pop;
   logic [dma_pkg::data_w-1:0] data_head;
   logic                       data_not_empty;
   logic                       data_pop;
   logic                       start;
   logic                       beat;
   logic                       active;
   logic                       rsp_err;
   logic                       in_error;

   assign desc_word = {desc_dest_addr, desc_length, desc_mode};

   dma_sync_fifo #(.width(dma_pkg::desc_w), .depth(4)) desc_queue (
      .clk       (clk),
      .reset_n   (reset_n),
      .push      (desc_push),
      .pop       (desc_pop),
      .push_data (desc_word),
      .pop_data  (desc_head),
      .full      (desc_full),
      .not_empty (desc_not_empty)
   );

   dma_sync_fifo #(.width(dma_pkg::data_w), .depth(32)) data_queue (
      .clk       (clk),
      .reset_n   (reset_n),
      .push      (data_push),
      .pop       (data_pop),
      .push_data (data_in),
      .pop_data  (data_head),
      .full      (data_full),
      .not_empty (data_not_empty)
   );

   write_dest_fsm i_write_dest_fsm (
      .clk              (clk),
      .reset_n          (reset_n),
      .desc_not_empty   (desc_not_empty),
      .desc_data        (desc_head),
      .desc_pop         (desc_pop),
      .data_not_empty   (data_not_empty),
      .data_rd          (data_head),
      .data_pop         (data_pop),
      .awvalid          (awvalid),
      .awaddr           (awaddr),
      .awlen            (awlen),
      .awburst          (awburst),
      .awready          (awready),
      .wvalid           (wvalid),
      .wdata            (wdata),
      .wlast            (wlast),
      .wready           (wready),
      .bvalid           (bvalid),
      .bresp            (bresp),
      .dispatcher_en    (dispatcher_en),
      .reset_dispatcher (reset_dispatcher),
      .wr_fsm_done      (wr_fsm_done),
      .wr_state         (wr_state),
      .start            (start),
      .beat             (beat),
      .active           (active),
      .rsp_err          (rsp_err),
      .in_error         (in_error)
   );

   dma_wr_status i_dma_wr_status (
      .clk              (clk),
      .reset_n          (reset_n),
      .start            (start),
      .beat             (beat),
      .active           (active),
      .rsp_err          (rsp_err),
      .in_error         (in_error),
      .busy             (busy),
      .stopped_on_error (stopped_on_error),
      .wr_rsp_err       (wr_rsp_err),
      .wr_clk_cnt       (wr_clk_cnt),
      .wr_valid_cnt     (wr_valid_cnt)
   );

endmodule

//--- sim/dma_write_tb.sv
/* Testbench for the DMA write top level with a file driven host, a bus responder
   with random back-pressure, result checks and a watchdog */

`timescale 1ns/1ps

module dma_write_tb;

   logic                            clk              = 1'b0;
   logic                            reset_n          = 1'b0;
   logic                            desc_push        = 1'b0;
   logic [dma_pkg::addr_w-1:0]      desc_dest_addr   = '0;
   logic [dma_pkg::length_w-1:0]    desc_length      = '0;
   dma_pkg::t_dma_mode              desc_mode        = dma_pkg::stand_by;
   logic                            data_push        = 1'b0;
   logic [dma_pkg::data_w-1:0]      data_in          = '0;
   logic                            awready          = 1'b0;
   logic                            wready           = 1'b0;
   logic                            bvalid           = 1'b0;
   dma_pkg::t_resp                  bresp            = dma_pkg::okay;
   logic                            dispatcher_en    = 1'b0;
   logic                            reset_dispatcher = 1'b0;
   logic                            desc_full;
   logic                            data_full;
   logic                            awvalid;
   logic [dma_pkg::addr_w-1:0]      awaddr;
   logic [dma_pkg::burst_len_w-1:0] awlen;
   dma_pkg::t_burst                 awburst;
   logic                            wvalid;
   logic [dma_pkg::data_w-1:0]      wdata;
   logic                            wlast;
   logic                            wr_fsm_done;
   dma_pkg::t_wr_state              wr_state;
   logic                            busy;
   logic                            stopped_on_error;
   logic                            wr_rsp_err;
   logic [dma_pkg::perf_cntr_w-1:0] wr_clk_cnt;
   logic [dma_pkg::perf_cntr_w-1:0] wr_valid_cnt;

   // Five words per descriptor hold the address, length, mode, response and reseed flag
   logic [31:0] tdata [0:319];
   logic [31:0] data_lfsr = 32'h7b0;
   logic [31:0] bp_lfsr   = 32'h7b0;
   logic [63:0] exp_beats [$];
   logic        loaded    = 1'b0;
   int          watchdog_cycles = 0;

   // Descriptor in flight as set by the host process
   logic [31:0] cur_addr   = '0;
   int          cur_len    = 0;
   logic [1:0]  cur_mode   = '0;
   logic [1:0]  cur_resp   = '0;
   int          cur_bursts = 0;
   int          aw_base    = 0;
   int          wl_base    = 0;
   int          done_base  = 0;

   // Running counts that only the bus model writes
   int          rd_idx     = 0;
   int          aw_count   = 0;
   int          wl_count   = 0;
   int          done_count = 0;
   int          w_in_burst = 0;
   int          cur_awlen  = 0;
   int          b_wait     = 0;
   logic [1:0]  b_code     = '0;

   always #10 clk = ~clk;

   dma_write_top i_dma_write_top (.*);

   // ************************************************************************
   // Reference rules and reporting
   // ************************************************************************

   // Fibonacci taps 32, 22, 2 and 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic int burst_count(input int len);
      return (len + dma_pkg::max_burst_beats - 1) / dma_pkg::max_burst_beats;
   endfunction

   function automatic int expected_awlen(input int len, input int k, input int n);
      if (k < n - 1) begin
         return dma_pkg::max_burst_beats - 1;
      end
      return len - dma_pkg::max_burst_beats * (n - 1) - 1;
   endfunction

   // Only ddr_to_host wraps
   function automatic dma_pkg::t_burst expected_burst(input logic [1:0] mode);
      if (mode == 2'd2) begin
         return dma_pkg::burst_wrap;
      end
      return dma_pkg::burst_incr;
   endfunction

   task automatic stop_run(input string what);
      $display("error: %s", what);
      $display("CHECKS FAILED");
      $fatal(1, "simulation stopped at the first failure");
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("error: %s is 0x%h, expected 0x%h", name, got, exp);
         $display("CHECKS FAILED");
         $fatal(1, "simulation stopped at the first failure");
      end
   endtask

   // ************************************************************************
   // Bus model with random ready levels, a response after each wlast and a monitor
   // ************************************************************************

   task automatic take_bit(output logic b);
      bp_lfsr = lfsr_next(bp_lfsr);
      b = bp_lfsr[0];
   endtask

   task automatic monitor_bus();
      int   k;
      logic r0;
      logic r1;
      if (awvalid && awready) begin
         k = aw_count - aw_base;
         if (k >= cur_bursts) begin
            stop_run("more address bursts than the descriptor length needs");
         end
         cur_awlen = expected_awlen(cur_len, k, cur_bursts);
         check_value("awaddr", 64'(awaddr),
                     64'(cur_addr + 32'(k * dma_pkg::max_burst_beats * dma_pkg::beat_bytes)));
         check_value("awlen", 64'(awlen), 64'(cur_awlen));
         check_value("awburst", 64'(awburst), 64'(expected_burst(cur_mode)));
         aw_count++;
      end
      if (wvalid && wready) begin
         if (rd_idx >= exp_beats.size()) begin
            stop_run("a write beat appeared with no pushed data left to match");
         end
         check_value("wdata", wdata, exp_beats[rd_idx]);
         check_value("wlast", 64'(wlast), 64'(w_in_burst == cur_awlen));
         rd_idx++;
         if (wlast) begin
            k = wl_count - wl_base;
            // Errors go only on the final burst of a descriptor
            b_code = (k == cur_bursts - 1) ? cur_resp : 2'd0;
            take_bit(r0);
            take_bit(r1);
            b_wait = ({r1, r0} == 2'd3) ? 2 : 2 + int'({r1, r0});
            wl_count++;
            w_in_burst = 0;
         end else begin
            w_in_burst++;
         end
      end
      if (wr_fsm_done) begin
         done_count++;
      end
   endtask

   always begin : bus_model
      logic bit_a;
      logic bit_b;
      @(posedge clk);
      take_bit(bit_a);
      take_bit(bit_b);
      awready <= bit_a | bit_b;
      take_bit(bit_a);
      take_bit(bit_b);
      wready <= bit_a | bit_b;
      bvalid <= 1'b0;
      if (b_wait == 1) begin
         bvalid <= 1'b1;
         bresp  <= dma_pkg::t_resp'(b_code);
      end
      if (b_wait != 0) begin
         b_wait = b_wait - 1;
      end
      @(negedge clk);
      if (reset_n) begin
         monitor_bus();
      end
   end

   // ************************************************************************
   // Host side
   // ************************************************************************

   task automatic push_descriptor(input logic [31:0] addr, input int len,
                                  input logic [1:0] mode);
      @(negedge clk);
      while (desc_full) @(negedge clk);
      @(posedge clk);
      desc_push      <= 1'b1;
      desc_dest_addr <= addr;
      desc_length    <= 8'(len);
      desc_mode      <= dma_pkg::t_dma_mode'(mode);
      @(posedge clk);
      desc_push <= 1'b0;
   endtask

   task automatic push_beats(input int len, input logic reseed);
      logic [63:0] word;
      int          b;
      int          j;
      if (reseed) begin
         data_lfsr = 32'h7b0;
      end
      for (b = 0; b < len; b++) begin
         for (j = 0; j < 64; j++) begin
            data_lfsr = lfsr_next(data_lfsr);
            word[j] = data_lfsr[0];
         end
         exp_beats.push_back(word);
         @(negedge clk);
         while (data_full) @(negedge clk);
         @(posedge clk);
         data_push <= 1'b1;
         data_in   <= word;
         @(posedge clk);
         data_push <= 1'b0;
      end
   endtask

   task automatic check_after_reset();
      check_value("awvalid", 64'(awvalid), 64'd0);
      check_value("wvalid", 64'(wvalid), 64'd0);
      check_value("wlast", 64'(wlast), 64'd0);
      check_value("wr_fsm_done", 64'(wr_fsm_done), 64'd0);
      check_value("busy", 64'(busy), 64'd0);
      check_value("stopped_on_error", 64'(stopped_on_error), 64'd0);
      check_value("wr_rsp_err", 64'(wr_rsp_err), 64'd0);
      check_value("wr_clk_cnt", 64'(wr_clk_cnt), 64'd0);
      check_value("wr_valid_cnt", 64'(wr_valid_cnt), 64'd0);
      check_value("wr_state", 64'(wr_state), 64'(dma_pkg::idle));
      check_value("desc_full", 64'(desc_full), 64'd0);
      check_value("data_full", 64'(data_full), 64'd0);
   endtask

   task automatic finish_good(input int len);
      check_value("wr_fsm_done", 64'(wr_fsm_done), 64'd1);
      @(negedge clk);
      check_value("wr_state", 64'(wr_state), 64'(dma_pkg::idle));
      check_value("wr_valid_cnt", 64'(wr_valid_cnt), 64'(len));
      if (wr_clk_cnt < 16'(len)) begin
         stop_run($sformatf("wr_clk_cnt is 0x%h, below the length 0x%h",
                            wr_clk_cnt, 16'(len)));
      end
      check_value("wr_rsp_err", 64'(wr_rsp_err), 64'd0);
      @(negedge clk);
      check_value("busy", 64'(busy), 64'd0);
      check_value("done pulses", 64'(done_count - done_base), 64'd1);
      check_value("completed bursts", 64'(wl_count - wl_base), 64'(cur_bursts));
   endtask

   task automatic finish_error(input int len);
      check_value("wr_state", 64'(wr_state), 64'(dma_pkg::error));
      check_value("wr_fsm_done", 64'(wr_fsm_done), 64'd0);
      @(negedge clk);
      check_value("stopped_on_error", 64'(stopped_on_error), 64'd1);
      check_value("wr_rsp_err", 64'(wr_rsp_err), 64'd1);
      check_value("busy", 64'(busy), 64'd1);
      check_value("wr_valid_cnt", 64'(wr_valid_cnt), 64'(len));
      check_value("done pulses", 64'(done_count - done_base), 64'd0);
      check_value("completed bursts", 64'(wl_count - wl_base), 64'(cur_bursts));
      @(posedge clk);
      reset_dispatcher <= 1'b1;
      @(posedge clk);
      reset_dispatcher <= 1'b0;
      @(negedge clk);
      check_value("wr_state", 64'(wr_state), 64'(dma_pkg::idle));
      check_value("wr_rsp_err", 64'(wr_rsp_err), 64'd1);
      @(negedge clk);
      check_value("stopped_on_error", 64'(stopped_on_error), 64'd0);
      check_value("busy", 64'(busy), 64'd0);
   endtask

   task automatic run_descriptor(input int idx);
      int len;
      len = int'(tdata[idx * 5 + 1]);
      @(posedge clk);
      cur_addr   = tdata[idx * 5];
      cur_len    = len;
      cur_mode   = 2'(tdata[idx * 5 + 2]);
      cur_resp   = 2'(tdata[idx * 5 + 3]);
      cur_bursts = burst_count(len);
      aw_base    = aw_count;
      wl_base    = wl_count;
      done_base  = done_count;
      push_descriptor(cur_addr, len, cur_mode);
      push_beats(len, tdata[idx * 5 + 4] != 32'd0);
      @(negedge clk);
      while (!wr_fsm_done && wr_state != dma_pkg::error) @(negedge clk);
      if (cur_resp == 2'd0) begin
         finish_good(len);
      end else begin
         finish_error(len);
      end
   endtask

   initial begin : host
      int n_records;
      int n_okay;
      int total_beats;
      int i;
      n_records   = 0;
      n_okay      = 0;
      total_beats = 0;
      $readmemh("sim/dma_write_testdata.txt", tdata);
      for (i = 0; i < 64; i++) begin
         if (tdata[i * 5 + 1] == 32'd0) break;
         n_records++;
         total_beats += int'(tdata[i * 5 + 1]);
         if (tdata[i * 5 + 3] == 32'd0) n_okay++;
      end
      if (n_records == 0) begin
         stop_run("no descriptors were found in the test data file");
      end
      watchdog_cycles = 200 * total_beats + 1000;
      loaded = 1'b1;
      repeat (2) @(posedge clk);
      reset_n       <= 1'b1;
      dispatcher_en <= 1'b1;
      @(negedge clk);
      check_after_reset();
      for (i = 0; i < n_records; i++) begin
         run_descriptor(i);
      end
      @(negedge clk);
      if (rd_idx == exp_beats.size() && done_count == n_okay) begin
         $display("ALL CHECKS PASSED");
         $finish;
      end else begin
         stop_run("beats or done pulses are missing at the end of the run");
      end
   end

   initial begin : watchdog
      wait (loaded);
      repeat (watchdog_cycles) @(posedge clk);
      stop_run("timeout, the descriptors did not complete in time");
   end

endmodule

//--- sim/dma_write_testdata.txt
// Write descriptors, all fields in hex: dest_addr length mode resp reseed
// mode 1 host_to_ddr, 2 ddr_to_host, 3 ddr_to_ddr; resp 0 okay, 2 slverr, 3 decerr
// resp applies to the final burst, earlier bursts always get okay
// reseed 1 restarts the data LFSR at its seed before the beats of that line
// A line with length 00 ends the list
00001000 01 1 0 1
00002000 10 1 0 0
00003000 11 2 0 0
00004000 05 3 2 0
00005000 20 1 0 0
00006000 0f 2 0 0
00007000 21 3 3 0
00008000 30 3 0 1
10000000 ff 1 0 0
00009080 64 2 0 0
0000a000 02 1 2 0
0000b000 1f 3 0 0
7ffffff0 12 1 0 0
0000c000 08 2 3 0
0000d000 80 3 0 0
00000000 00 0 0 0

//--- sim.f
source/dma_pkg.sv
source/dma_sync_fifo.sv
source/write_dest_fsm.sv
source/dma_wr_status.sv
source/dma_write_top.sv
sim/dma_write_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for a pass"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --top-module dma_write_tb -f sim.f
	./obj_dir/Vdma_write_tb | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
